//--- sme.f
sme_pkg.sv
sme_loader.sv
sme_preprocess.sv
sme_comparator.sv
sme_control.sv
sme_top.sv
tb_clock_gen.sv
sme_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sme_tb
FILELIST = sme.f
LOG      = sim.log
SIM      = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sme_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sme_tb;
    import sme_pkg::*;

    localparam int num_directed   = 21;
    localparam int num_random     = 40;
    localparam int timeout_cycles = 60 * (num_directed + num_random) + 40;

    logic       clk;
    logic       reset;
    char_t      chardata;
    logic       isstring;
    logic       ispattern;
    logic       valid;
    logic       match;
    str_index_t match_index;

    char_t      cur_str [$];
    char_t      cur_pat [$];
    logic       exp_match;
    str_index_t exp_index;
    logic       job_active  = 1'b0;
    int         valid_count = 0;
    int         cycle_count = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    sme_top dut (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    task automatic end_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t: %s", $time, what);
        end_with_failure();
    endtask

    // first start position of the pattern in cur_str, or -1
    function automatic int find_first();
        char_t core [$];
        bit    head;
        bit    tail;
        bit    ok;
        int    n;
        int    last;
        n    = cur_str.size();
        head = (cur_pat.size() > 0) && (cur_pat[0] == char_hat);
        tail = (cur_pat.size() > int'(head)) && (cur_pat[cur_pat.size() - 1] == char_dollar);
        core = cur_pat;
        if (tail)
        begin
            void'(core.pop_back());
        end
        if (head)
        begin
            void'(core.pop_front());
        end
        last = n - core.size();
        // match_index has only 5 bits
        if (last > max_string_len - 1)
        begin
            last = max_string_len - 1;
        end
        for (int p = 0; p <= last; p++)
        begin
            ok = 1'b1;
            foreach (core[i])
            begin
                if (core[i] != char_dot && core[i] != cur_str[p + i])
                begin
                    ok = 1'b0;
                end
            end
            if (head && p > 0 && cur_str[p - 1] != char_space)
            begin
                ok = 1'b0;
            end
            if (tail && p + core.size() < n && cur_str[p + core.size()] != char_space)
            begin
                ok = 1'b0;
            end
            if (ok)
            begin
                return p;
            end
        end
        return -1;
    endfunction

    task automatic wait_for_valid();
        do
        begin
            @(negedge clk);
        end
        while (!valid);
        @(posedge clk);
        job_active = 1'b0;
    endtask

    task automatic run_job(input bit with_string);
        int pos;
        int pulses_before;
        pos           = find_first();
        exp_match     = (pos >= 0);
        exp_index     = (pos >= 0) ? str_index_t'(pos) : '0;
        pulses_before = valid_count;
        job_active    = 1'b1;
        if (with_string)
        begin
            foreach (cur_str[i])
            begin
                @(negedge clk);
                isstring  = 1'b1;
                ispattern = 1'b0;
                chardata  = cur_str[i];
            end
        end
        foreach (cur_pat[i])
        begin
            @(negedge clk);
            isstring  = 1'b0;
            ispattern = 1'b1;
            chardata  = cur_pat[i];
        end
        @(negedge clk);
        isstring  = 1'b0;
        ispattern = 1'b0;
        chardata  = '0;
        wait_for_valid();
        assert (valid_count == pulses_before + 1)
        else report_mismatch("valid pulse count", pulses_before + 1, valid_count);
    endtask

    task automatic send_job(input string s, input string p);
        cur_str.delete();
        cur_pat.delete();
        for (int i = 0; i < s.len(); i++)
        begin
            cur_str.push_back(char_t'(s[i]));
        end
        for (int i = 0; i < p.len(); i++)
        begin
            cur_pat.push_back(char_t'(p[i]));
        end
        run_job(1'b1);
    endtask

    // reuses the string already loaded
    task automatic send_pattern(input string p);
        cur_pat.delete();
        for (int i = 0; i < p.len(); i++)
        begin
            cur_pat.push_back(char_t'(p[i]));
        end
        run_job(1'b0);
    endtask

    task automatic random_job(input bit first);
        string alphabet;
        bit    with_string;
        int    n;
        alphabet    = "abc ^$.";
        with_string = first || ($urandom % 4 != 0);
        if (with_string)
        begin
            cur_str.delete();
            n = 1 + int'($urandom % 32);
            repeat (n) cur_str.push_back(char_t'(alphabet[$urandom % alphabet.len()]));
        end
        cur_pat.delete();
        n = 1 + int'($urandom % 8);
        repeat (n) cur_pat.push_back(char_t'(alphabet[$urandom % alphabet.len()]));
        run_job(with_string);
    endtask

    always @(negedge clk)
    begin
        if (!reset && valid)
        begin
            valid_count = valid_count + 1;
            assert (job_active)
            else report_problem("valid pulsed while no job was in flight");
        end
    end

    // result on every valid pulse
    assert property (@(negedge clk) disable iff (reset) valid |-> (match == exp_match))
    else report_mismatch("match", int'(exp_match), int'(match));

    assert property (@(negedge clk) disable iff (reset)
                     (valid && exp_match) |-> (match_index == exp_index))
    else report_mismatch("match_index", int'(exp_index), int'(match_index));

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles)
        begin
            report_problem("timeout, valid never came for the running job");
        end
    end

    initial
    begin
        int seed_draw;
        chardata  = '0;
        isstring  = 1'b0;
        ispattern = 1'b0;
        seed_draw = $urandom(31);
        @(negedge reset);
        @(negedge clk);
        assert (valid == 1'b0) else report_mismatch("valid", 0, int'(valid));
        assert (match == 1'b0) else report_mismatch("match", 0, int'(match));
        assert (match_index == '0) else report_mismatch("match_index", 0, int'(match_index));

        // literals
        send_job("hello world", "world");
        send_pattern("xyz");
        send_job("abcabcabd", "abd");
        // wildcard
        send_job("the cat sat", "s.t");
        send_pattern("....");
        send_pattern("c.t");
        // head anchor
        send_job("cat scatter cat", "^cat");
        send_job("scatter cat", "^cat");
        send_job("scatter", "^cat");
        // tail anchor, then both
        send_job("bobcat dog", "cat$");
        send_job("dog bobcat", "cat$");
        send_job("cats dogs", "cat$");
        send_job("a cat catalog", "^cat$");
        send_pattern("^cata$");
        // several patterns on one string
        send_job("the quick brown fox", "quick");
        send_pattern("o.n");
        send_pattern("^fox$");
        send_pattern("zebra");
        send_job("abcdefghijklmnopqrstuvwxyz012345", "yz012345");
        send_pattern("c^d");
        send_job("abc", "abcd");

        for (int j = 0; j < num_random; j++)
        begin
            random_job(j == 0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int half_period  = 5;
    localparam int reset_cycles = 8;

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release on a falling edge, away from the DUT's sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- sme_top.sv
`timescale 1ns/1ps
`default_nettype none

module sme_top (
    input  logic                clk,
    input  logic                reset,
    input  sme_pkg::char_t      chardata,
    input  logic                isstring,
    input  logic                ispattern,
    output logic                valid,
    output logic                match,
    output sme_pkg::str_index_t match_index
);
    import sme_pkg::*;

    logic     string_clear;
    logic     pattern_clear;
    logic     pre_start;
    logic     pre_done;
    logic     cmp_start;
    logic     cmp_done;
    char_t    string_chars [max_string_len];
    char_t    pattern_chars [max_pattern_len];
    char_t    core_chars [max_pattern_len];
    str_len_t str_len;
    pat_len_t pat_len;
    pat_len_t core_len;
    logic     head_anchor;
    logic     tail_anchor;

    sme_control u_control (
        .clk           (clk),
        .reset         (reset),
        .isstring      (isstring),
        .ispattern     (ispattern),
        .pre_done      (pre_done),
        .cmp_done      (cmp_done),
        .string_clear  (string_clear),
        .pattern_clear (pattern_clear),
        .pre_start     (pre_start),
        .cmp_start     (cmp_start),
        .valid         (valid)
    );

    sme_loader u_loader (
        .clk           (clk),
        .reset         (reset),
        .chardata      (chardata),
        .isstring      (isstring),
        .ispattern     (ispattern),
        .string_clear  (string_clear),
        .pattern_clear (pattern_clear),
        .string_chars  (string_chars),
        .str_len       (str_len),
        .pattern_chars (pattern_chars),
        .pat_len       (pat_len)
    );

    sme_preprocess u_preprocess (
        .clk           (clk),
        .reset         (reset),
        .start         (pre_start),
        .pattern_chars (pattern_chars),
        .pat_len       (pat_len),
        .core_chars    (core_chars),
        .core_len      (core_len),
        .head_anchor   (head_anchor),
        .tail_anchor   (tail_anchor),
        .done          (pre_done)
    );

    sme_comparator u_comparator (
        .clk          (clk),
        .reset        (reset),
        .start        (cmp_start),
        .string_chars (string_chars),
        .str_len      (str_len),
        .core_chars   (core_chars),
        .core_len     (core_len),
        .head_anchor  (head_anchor),
        .tail_anchor  (tail_anchor),
        .done         (cmp_done),
        .match        (match),
        .match_index  (match_index)
    );

endmodule

`default_nettype wire

//--- sme_control.sv
`timescale 1ns/1ps
`default_nettype none

module sme_control (
    input  logic clk,
    input  logic reset,
    input  logic isstring,
    input  logic ispattern,
    input  logic pre_done,
    input  logic cmp_done,
    output logic string_clear,
    output logic pattern_clear,
    output logic pre_start,
    output logic cmp_start,
    output logic valid
);
    import sme_pkg::*;

    sme_state_t state;
    sme_state_t state_next;
    logic       accept_new;

    always_comb
    begin
        accept_new    = (state == idle) || (state == done);
        string_clear  = accept_new && isstring;
        pattern_clear = ispattern && (state != rd_pattern);
        state_next    = state;
        case (state)
            idle, done, rd_string:
            begin
                if (isstring)
                    state_next = rd_string;
                else if (ispattern)
                    state_next = rd_pattern;
                else
                    state_next = idle;
            end
            rd_pattern:
            begin
                if (!ispattern)
                    state_next = preprocess;
            end
            preprocess:
            begin
                if (pre_done)
                    state_next = compare;
            end
            compare:
            begin
                if (cmp_done)
                    state_next = done;
            end
            default:
            begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= idle;
            pre_start <= 1'b0;
            cmp_start <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            // high in the first cycle of the new state
            pre_start <= (state == rd_pattern) && (state_next == preprocess);
            cmp_start <= (state == preprocess) && (state_next == compare);
        end
    end

    // done lasts exactly one cycle
    assign valid = (state == done);

endmodule

`default_nettype wire

//--- sme_comparator.sv
`timescale 1ns/1ps
`default_nettype none

module sme_comparator (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  sme_pkg::char_t     string_chars [sme_pkg::max_string_len],
    input  sme_pkg::str_len_t  str_len,
    input  sme_pkg::char_t     core_chars [sme_pkg::max_pattern_len],
    input  sme_pkg::pat_len_t  core_len,
    input  logic               head_anchor,
    input  logic               tail_anchor,
    output logic               done,
    output logic               match,
    output sme_pkg::str_index_t match_index
);
    import sme_pkg::*;

    logic     busy;
    str_len_t pos;
    str_len_t core_len_ext;
    str_len_t end_pos;
    str_len_t last_pos;
    logic     too_long;
    logic     at_last;
    logic     chars_ok;
    logic     head_ok;
    logic     tail_ok;
    logic     hit;

    always_comb
    begin
        core_len_ext = str_len_t'(core_len);
        end_pos      = pos + core_len_ext;
        last_pos     = str_len - core_len_ext;
        too_long     = core_len_ext > str_len;
        // an empty core could ask for position 32, which has no index
        at_last      = (pos == last_pos) || (pos == str_len_t'(max_string_len - 1));
    end

    // window at pos against every core character
    always_comb
    begin
        chars_ok = 1'b1;
        for (int i = 0; i < max_pattern_len; i++)
        begin
            if (pat_len_t'(i) < core_len)
            begin
                if (core_chars[i] != char_dot
                    && core_chars[i] != string_chars[str_index_t'(pos + str_len_t'(i))])
                begin
                    chars_ok = 1'b0;
                end
            end
        end
    end

    // anchor neighbours
    always_comb
    begin
        head_ok = !head_anchor || (pos == '0)
                  || (string_chars[str_index_t'(pos - 1'b1)] == char_space);
        tail_ok = !tail_anchor || (end_pos == str_len)
                  || (string_chars[str_index_t'(end_pos)] == char_space);
        hit     = chars_ok && head_ok && tail_ok;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy        <= 1'b0;
            pos         <= '0;
            done        <= 1'b0;
            match       <= 1'b0;
            match_index <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy <= 1'b1;
                pos  <= '0;
            end
            else if (busy)
            begin
                if (too_long)
                begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    match <= 1'b0;
                end
                else if (hit)
                begin
                    busy        <= 1'b0;
                    done        <= 1'b1;
                    match       <= 1'b1;
                    match_index <= str_index_t'(pos);
                end
                else if (at_last)
                begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    match <= 1'b0;
                end
                else
                begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sme_preprocess.sv
`timescale 1ns/1ps
`default_nettype none

module sme_preprocess (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  sme_pkg::char_t    pattern_chars [sme_pkg::max_pattern_len],
    input  sme_pkg::pat_len_t pat_len,
    output sme_pkg::char_t    core_chars [sme_pkg::max_pattern_len],
    output sme_pkg::pat_len_t core_len,
    output logic              head_anchor,
    output logic              tail_anchor,
    output logic              done
);
    import sme_pkg::*;

    logic     has_hat;
    logic     has_dollar;
    pat_len_t last_idx;

    always_comb
    begin
        last_idx   = pat_len - 1'b1;
        has_hat    = (pat_len != '0) && (pattern_chars[0] == char_hat);
        // a lone '^' must not also count as the trailing '$'
        has_dollar = (pat_len > pat_len_t'(has_hat))
                     && (pattern_chars[last_idx[2:0]] == char_dollar);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            core_len    <= '0;
            head_anchor <= 1'b0;
            tail_anchor <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            done <= start;
            if (start)
            begin
                core_len    <= pat_len - pat_len_t'(has_hat) - pat_len_t'(has_dollar);
                head_anchor <= has_hat;
                tail_anchor <= has_dollar;
            end
        end
    end

    // shift left past the '^'; a trailing '$' just falls outside core_len
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            for (int i = 0; i < max_pattern_len - 1; i++)
            begin
                core_chars[i] <= has_hat ? pattern_chars[i + 1] : pattern_chars[i];
            end
            core_chars[max_pattern_len - 1] <= has_hat ? '0 : pattern_chars[max_pattern_len - 1];
        end
    end

endmodule

`default_nettype wire

//--- sme_loader.sv
`timescale 1ns/1ps
`default_nettype none

module sme_loader (
    input  logic            clk,
    input  logic            reset,
    input  sme_pkg::char_t  chardata,
    input  logic            isstring,
    input  logic            ispattern,
    input  logic            string_clear,
    input  logic            pattern_clear,
    output sme_pkg::char_t  string_chars [sme_pkg::max_string_len],
    output sme_pkg::str_len_t str_len,
    output sme_pkg::char_t  pattern_chars [sme_pkg::max_pattern_len],
    output sme_pkg::pat_len_t pat_len
);
    import sme_pkg::*;

    str_len_t str_base;
    pat_len_t pat_base;
    logic     str_wr;
    logic     pat_wr;

    // a clear arrives together with the first character of the new string or pattern
    always_comb
    begin
        str_base = string_clear ? '0 : str_len;
        pat_base = pattern_clear ? '0 : pat_len;
        str_wr   = isstring && (str_base < str_len_t'(max_string_len));
        pat_wr   = ispattern && (pat_base < pat_len_t'(max_pattern_len));
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            str_len <= '0;
            pat_len <= '0;
        end
        else
        begin
            str_len <= str_wr ? str_base + 1'b1 : str_base;
            pat_len <= pat_wr ? pat_base + 1'b1 : pat_base;
        end
    end

    always_ff @(posedge clk)
    begin
        if (str_wr)
        begin
            string_chars[str_index_t'(str_base)] <= chardata;
        end
        // characters past the buffer end are dropped
        if (pat_wr)
        begin
            pattern_chars[pat_base[2:0]] <= chardata;
        end
    end

endmodule

`default_nettype wire

//--- sme_pkg.sv
`default_nettype none

package sme_pkg;

    localparam int char_width      = 8;
    localparam int max_string_len  = 32;
    localparam int max_pattern_len = 8;
    localparam int index_width     = 5;
    // one extra bit so that a full pattern of 8 still fits
    localparam int plen_width      = 4;

    typedef logic [char_width-1:0]  char_t;
    typedef logic [index_width-1:0] str_index_t;
    // lengths run 0..32, hence the extra bit
    typedef logic [index_width:0]   str_len_t;
    typedef logic [plen_width-1:0]  pat_len_t;

    // special characters
    localparam char_t char_hat    = 8'h5e;
    localparam char_t char_dollar = 8'h24;
    localparam char_t char_dot    = 8'h2e;
    localparam char_t char_space  = 8'h20;

    typedef enum logic [2:0] {
        idle,
        rd_string,
        rd_pattern,
        preprocess,
        compare,
        done
    } sme_state_t;

endpackage

`default_nettype wire
